//--- riscv_hart_top.f
+incdir+dv
source/riscv_hart_pkg.sv
source/riscv_alu.sv
source/riscv_regfile.sv
source/riscv_hart_core.sv
source/port_switch.sv
source/riscv_hart_top.sv
dv/riscv_hart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_hart_tb
FILELIST  ?= riscv_hart_top.f
BUILD_DIR ?= build
LOG       ?= sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) dv/riscv_hart_tb_model.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/riscv_hart_tb_model.svh
`ifndef RISCV_HART_TB_MODEL_SVH
`define RISCV_HART_TB_MODEL_SVH

localparam int MEM_WORDS = 1024;
// fetch up to 7, exec 1, memory up to 7, wb 1
localparam int WORST_CPI = 16;

integer      seed;
logic [31:0] prog [$];
logic [31:0] model_mem [0:MEM_WORDS-1];
logic [31:0] per_rd_vals [$];
// expected traces, consumed by the responders
logic [31:0] exp_fetch_pc [$];
logic [31:0] exp_ref_pc [$];
logic [31:0] exp_ref_addr [$];
logic [31:0] exp_per_addr [$];
logic [31:0] exp_per_data [$];

function automatic int unsigned pick(input int unsigned n);
	return {$random(seed)} % n;
endfunction

// background pattern, mixes every address bit
function automatic logic [31:0] fill_word(input int unsigned idx);
	return (idx * 32'h9e37_79b9) ^ {idx[15:0], ~idx[15:0]};
endfunction

// ---------------------------------------------------------------------------
// rv32i encoders
// ---------------------------------------------------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
	return {imm, rd, LUI};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

// ---------------------------------------------------------------------------
// random program
// ---------------------------------------------------------------------------
function automatic logic [31:0] rand_alu();
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] f3;
	logic [31:0] v;
	rd  = 5'(pick(32));
	rs1 = 5'(pick(32));
	rs2 = 5'(pick(32));
	v   = $random(seed);
	f3  = 3'(pick(8));
	case (pick(4))
		0: begin
			// add slt xor or and, odd codes other than 7 bumped up
			if (f3[0] && f3 != 3'd7)
				f3 = f3 + 3'd1;
			return enc_r(7'h00, rs2, rs1, f3, rd);
		end
		1: return enc_r(7'h20, rs2, rs1, 3'b000, rd);
		// addi xori ori andi
		2: return enc_i(v[11:0], rs1, {|f3[1:0], f3[1], &f3[1:0]}, rd, OP_IMM);
		default: return enc_u(v[19:0], rd);
	endcase
endfunction

task automatic add_mem_op();
	logic [11:0] imm;
	logic [4:0]  base;
	base = 5'd0;
	if (pick(2) == 0) begin
		imm = 12'h400 + 12'(4 * pick(256));
	end else begin
		// peripheral base reloaded every time
		base = 5'd31;
		prog.push_back(enc_u(20'h80000, 5'd31));
		imm = 12'(4 * pick(64));
	end
	if (pick(2) == 0)
		prog.push_back(enc_s(imm, 5'(pick(32)), base));
	else
		prog.push_back(enc_i(imm, base, 3'b010, 5'(pick(32)), LOAD));
endtask

task automatic build_program();
	logic [31:0] v;
	prog.delete();
	for (int r = 1; r < 32; r++) begin
		v = $random(seed);
		prog.push_back(enc_u(v[31:12], 5'(r)));
		prog.push_back(enc_i(v[11:0], 5'(r), 3'b000, 5'(r), OP_IMM));
	end
	repeat (40) prog.push_back(rand_alu());
	repeat (12) add_mem_op();
	// forward beq or bne, then jal, each over one instruction
	prog.push_back(enc_b(13'd8, 5'(pick(32)), 5'(pick(32)), {2'b00, 1'(pick(2))}));
	prog.push_back(rand_alu());
	prog.push_back(enc_j(21'd8, 5'(pick(32))));
	prog.push_back(rand_alu());
	// dump x0..x31 to peripheral space
	prog.push_back(enc_u(20'h80000, 5'd31));
	for (int r = 0; r < 32; r++)
		prog.push_back(enc_s(12'h100 + 12'(4 * r), 5'(r), 5'd31));
	// park on a self loop
	prog.push_back(enc_j(21'd0, 5'd0));
	repeat (64) per_rd_vals.push_back($random(seed));
endtask

// ---------------------------------------------------------------------------
// isa reference model
// ---------------------------------------------------------------------------
task automatic run_model();
	logic [31:0] x [0:31];
	logic [31:0] pc;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] res;
	logic [31:0] addr;
	logic [31:0] next;
	logic        wr;
	int          rd_idx;
	for (int i = 0; i < 32; i++)
		x[i] = '0;
	pc     = '0;
	rd_idx = 0;
	for (int n = 0; n < 4 * MEM_WORDS; n++) begin
		w = prog[pc[31:2]];
		exp_fetch_pc.push_back(pc);
		if (w == enc_j(21'd0, 5'd0))
			break;
		a    = x[w[19:15]];
		b    = x[w[24:20]];
		imm  = {{20{w[31]}}, w[31:20]};
		next = pc + 32'd4;
		wr   = 1'b1;
		res  = '0;
		case (w[6:0])
			OP, OP_IMM: begin
				if (w[6:0] == OP_IMM)
					b = imm;
				case (w[14:12])
					3'b000:  res = (w[6:0] == OP && w[30]) ? a - b : a + b;
					3'b010:  res = {31'b0, $signed(a) < $signed(b)};
					3'b100:  res = a ^ b;
					3'b110:  res = a | b;
					default: res = a & b;
				endcase
			end
			LUI: res = {w[31:12], 12'b0};
			LOAD: begin
				addr = a + imm;
				exp_ref_pc.push_back(pc);
				exp_ref_addr.push_back(addr);
				if (addr >= PER_BASE) begin
					res = per_rd_vals[rd_idx];
					rd_idx++;
				end else begin
					res = model_mem[addr[11:2]];
				end
			end
			STORE: begin
				wr   = 1'b0;
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				exp_ref_pc.push_back(pc);
				exp_ref_addr.push_back(addr);
				if (addr >= PER_BASE) begin
					exp_per_addr.push_back(addr);
					exp_per_data.push_back(b);
				end else begin
					model_mem[addr[11:2]] = b;
				end
			end
			BRANCH: begin
				wr = 1'b0;
				if ((a == b) != w[12])
					next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			end
			default: begin
				res  = pc + 32'd4;
				next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
		endcase
		if (wr && w[11:7] != 5'd0)
			x[w[11:7]] = res;
		pc = next;
	end
endtask

`endif

//--- dv/riscv_hart_tb.sv
`timescale 1ns/1ps

module riscv_hart_tb import riscv_hart_pkg::*; ();

	logic        clock_bus_i;
	logic        reset_i;
	exc_e        exception_bus_o;
	logic [31:0] inst_addr_o;
	logic        mem_req0_o;
	logic [31:0] mem_add0_o;
	logic [31:0] mem_data0_i;
	logic        mem_done0_i;
	logic        mem_req1_o;
	logic        mem_rw1_o;
	logic [31:0] mem_add1_o;
	logic [31:0] mem_data1_o;
	logic [31:0] mem_data1_i;
	logic        mem_done1_i;
	logic        per_req_o;
	logic        per_rw_o;
	logic [31:0] per_add_o;
	logic [31:0] per_data_o;
	logic [31:0] per_data_i;

	`include "riscv_hart_tb_model.svh"

	// shared by both memory ports
	logic [31:0] mem [0:MEM_WORDS-1];
	int          fail_count;
	int          cycles;
	int          cycle_limit;
	int          per_rd_idx;
	logic        busy0;
	logic        busy1;
	int          wait0;
	int          wait1;

	riscv_hart_top #(
		.RESET_PC (32'h0000_0000)
	) riscv_hart_top_i (.*);

	initial begin
		clock_bus_i = 1'b0;
		forever #20 clock_bus_i = ~clock_bus_i;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			fail_count++;
			$display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	// every data reference must belong to a modeled load or store
	task automatic check_data_ref(input logic [31:0] addr);
		if (exp_ref_pc.size() == 0) begin
			$display("data reference at %h that the program does not make", addr);
			abort_run();
		end else begin
			check_equal(inst_addr_o, exp_ref_pc.pop_front(), "pc of data reference");
			check_equal(addr, exp_ref_addr.pop_front(), "data reference address");
		end
	endtask

	// ------------------------------------------------------------------------
	// responders, all act 1 ns after the edge
	// ------------------------------------------------------------------------
	// instruction port
	always @(posedge clock_bus_i) begin
		#1;
		if (reset_i || mem_done0_i) begin
			mem_done0_i = 1'b0;
			busy0       = 1'b0;
		end else begin
			if (mem_req0_o && !busy0) begin
				busy0 = 1'b1;
				wait0 = pick(6);
				if (exp_fetch_pc.size() > 0)
					check_equal(mem_add0_o, exp_fetch_pc.pop_front(), "fetch address");
			end
			if (busy0 && wait0 == 0) begin
				mem_done0_i = 1'b1;
				mem_data0_i = mem[mem_add0_o[11:2]];
			end else if (busy0) begin
				wait0--;
			end
		end
	end

	// data port into memory
	always @(posedge clock_bus_i) begin
		#1;
		if (!reset_i)
			check_equal({31'b0, mem_req1_o && per_req_o}, 32'd0, "both data sides requested");
		if (reset_i || mem_done1_i) begin
			mem_done1_i = 1'b0;
			busy1       = 1'b0;
		end else begin
			if (mem_req1_o && !busy1) begin
				busy1 = 1'b1;
				wait1 = pick(6);
				check_data_ref(mem_add1_o);
			end
			if (busy1 && wait1 == 0) begin
				mem_done1_i = 1'b1;
				if (mem_rw1_o)
					mem[mem_add1_o[11:2]] = mem_data1_o;
				else
					mem_data1_i = mem[mem_add1_o[11:2]];
			end else if (busy1) begin
				wait1--;
			end
		end
	end

	// peripheral, req is a single cycle per reference
	always @(posedge clock_bus_i) begin
		#1;
		if (!reset_i && per_req_o) begin
			check_data_ref(per_add_o);
			if (per_rw_o) begin
				check_equal(per_add_o, exp_per_addr.pop_front(), "peripheral write address");
				check_equal(per_data_o, exp_per_data.pop_front(), "peripheral write data");
			end else begin
				per_data_i = per_rd_vals[per_rd_idx];
				per_rd_idx++;
			end
		end
	end

	// run limit
	always @(posedge clock_bus_i) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: the hart stopped making progress after %0d cycles", cycles);
			abort_run();
		end
	end

	task automatic apply_reset();
		@(posedge clock_bus_i);
		#1 reset_i = 1'b1;
		repeat (16) @(posedge clock_bus_i);
		#1 reset_i = 1'b0;
	endtask

	// one short program whose second instruction faults
	task automatic run_fault(input logic [31:0] word, input exc_e expected, input string what);
		mem[0] = enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM);
		mem[1] = word;
		apply_reset();
		while (exception_bus_o == EXC_NONE)
			@(posedge clock_bus_i);
		#1;
		check_equal(32'(exception_bus_o), 32'(expected), what);
		repeat (8) begin
			@(posedge clock_bus_i);
			#1;
			check_equal({29'b0, mem_req0_o, mem_req1_o, per_req_o}, 32'd0, "request after halt");
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		reset_i     = 1'b1;
		mem_data0_i = '0;
		mem_done0_i = 1'b0;
		mem_data1_i = '0;
		mem_done1_i = 1'b0;
		per_data_i  = '0;
		busy0       = 1'b0;
		busy1       = 1'b0;
		fail_count  = 0;
		cycles      = 0;
		per_rd_idx  = 0;
		seed        = 32'h4137_5047;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]       = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		build_program();
		foreach (prog[i]) begin
			mem[i]       = prog[i];
			model_mem[i] = prog[i];
		end
		run_model();
		cycle_limit = 20 * (prog.size() + 6) * WORST_CPI + 100;

		// random program against the model
		apply_reset();
		while (exp_per_addr.size() != 0)
			@(posedge clock_bus_i);
		repeat (4) @(posedge clock_bus_i);
		check_equal(32'(exp_ref_pc.size()), 32'd0, "data references left over");
		// the self loop at the end is the last modeled fetch
		check_equal(32'(exp_fetch_pc.size()), 32'd0, "fetches left over");
		check_equal(32'(exception_bus_o), 32'(EXC_NONE), "exception in random program");
		for (int i = 256; i < 512; i++)
			check_equal(mem[i], model_mem[i], "memory word after stores");

		// reset mid-run, then faulting programs
		run_fault(enc_i(12'h402, 5'd0, 3'b010, 5'd2, LOAD), EXC_LOAD_MISALIGN, "load misalign");
		run_fault(32'hffff_ffff, EXC_ILLEGAL, "illegal opcode");

		if (fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- source/riscv_hart_top.sv
`timescale 1ns/1ps

module riscv_hart_top import riscv_hart_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	// system
	input  logic            clock_bus_i,
	input  logic            reset_i,
	output exc_e            exception_bus_o,
	output logic [XLEN-1:0] inst_addr_o,

	// instruction side of internal memory
	output logic            mem_req0_o,
	output logic [XLEN-1:0] mem_add0_o,
	input  logic [XLEN-1:0] mem_data0_i,
	input  logic            mem_done0_i,

	// data side of internal memory
	output logic            mem_req1_o,
	output logic            mem_rw1_o,
	output logic [XLEN-1:0] mem_add1_o,
	output logic [XLEN-1:0] mem_data1_o,
	input  logic [XLEN-1:0] mem_data1_i,
	input  logic            mem_done1_i,

	// peripheral controller
	output logic            per_req_o,
	output logic            per_rw_o,
	output logic [XLEN-1:0] per_add_o,
	output logic [XLEN-1:0] per_data_o,
	input  logic [XLEN-1:0] per_data_i
);

	// ------------------------------------------------------------------------
	// hart data port, between core and switch
	// ------------------------------------------------------------------------
	logic            hart_data_req;
	logic            hart_data_rw;
	logic [XLEN-1:0] hart_data_add;
	logic [XLEN-1:0] hart_data_wdata;
	logic [XLEN-1:0] hart_data_rdata;
	logic            hart_data_done;

	// core, instruction port straight to memory port 0
	riscv_hart_core #(
		.RESET_PC (RESET_PC)
	) hart_inst (
		.clock_bus_i     (clock_bus_i),
		.reset_i         (reset_i),
		.inst_req_o      (mem_req0_o),
		.inst_addr_o     (mem_add0_o),
		.inst_data_i     (mem_data0_i),
		.inst_done_i     (mem_done0_i),
		.data_req_o      (hart_data_req),
		.data_wren_o     (hart_data_rw),
		.data_addr_o     (hart_data_add),
		.data_data_o     (hart_data_wdata),
		.data_data_i     (hart_data_rdata),
		.data_done_i     (hart_data_done),
		// pc of the instruction owning the data reference
		.data_ref_addr_o (inst_addr_o),
		.exception_o     (exception_bus_o)
	);

	// address decode between memory port 1 and the peripheral bus
	port_switch peripheral_switch_inst (
		.clock_bus_i       (clock_bus_i),
		.reset_i           (reset_i),
		.core_req_i        (hart_data_req),
		.core_wren_i       (hart_data_rw),
		.core_addr_i       (hart_data_add),
		.core_data_i       (hart_data_wdata),
		.core_done_o       (hart_data_done),
		.core_data_o       (hart_data_rdata),
		.memory_done_i     (mem_done1_i),
		.memory_data_i     (mem_data1_i),
		.memory_req_o      (mem_req1_o),
		.memory_wren_o     (mem_rw1_o),
		.memory_addr_o     (mem_add1_o),
		.memory_data_o     (mem_data1_o),
		.peripheral_data_i (per_data_i),
		.peripheral_req_o  (per_req_o),
		.peripheral_wren_o (per_rw_o),
		.peripheral_addr_o (per_add_o),
		.peripheral_data_o (per_data_o)
	);

endmodule

//--- source/port_switch.sv
`timescale 1ns/1ps

module port_switch import riscv_hart_pkg::*; (
	input  logic            clock_bus_i,
	input  logic            reset_i,
	// core side
	input  logic            core_req_i,
	input  logic            core_wren_i,
	input  logic [XLEN-1:0] core_addr_i,
	input  logic [XLEN-1:0] core_data_i,
	output logic            core_done_o,
	output logic [XLEN-1:0] core_data_o,
	// internal memory side
	input  logic            memory_done_i,
	input  logic [XLEN-1:0] memory_data_i,
	output logic            memory_req_o,
	output logic            memory_wren_o,
	output logic [XLEN-1:0] memory_addr_o,
	output logic [XLEN-1:0] memory_data_o,
	// peripheral side, no done
	input  logic [XLEN-1:0] peripheral_data_i,
	output logic            peripheral_req_o,
	output logic            peripheral_wren_o,
	output logic [XLEN-1:0] peripheral_addr_o,
	output logic [XLEN-1:0] peripheral_data_o
);

	logic            sel_per;
	logic            per_done_q;
	logic [XLEN-1:0] per_rdata_q;

	// address decode
	assign sel_per = (core_addr_i >= PER_BASE);

	// memory path, no added cycles
	assign memory_req_o  = core_req_i && !sel_per;
	assign memory_wren_o = core_wren_i;
	assign memory_addr_o = core_addr_i;
	assign memory_data_o = core_data_i;

	// peripheral sees a single cycle of req per reference
	assign peripheral_req_o  = core_req_i && sel_per && !per_done_q;
	assign peripheral_wren_o = core_wren_i;
	assign peripheral_addr_o = core_addr_i;
	assign peripheral_data_o = core_data_i;

	// local done one cycle after the request, clears for the next one
	always_ff @(posedge clock_bus_i) begin
		if (reset_i)
			per_done_q <= 1'b0;
		else
			per_done_q <= peripheral_req_o;
	end

	// read data captured with the request cycle
	always_ff @(posedge clock_bus_i) begin
		if (peripheral_req_o)
			per_rdata_q <= peripheral_data_i;
	end

	// return path back to the core
	assign core_done_o = sel_per ? per_done_q : memory_done_i;
	assign core_data_o = sel_per ? per_rdata_q : memory_data_i;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	assert property (@(posedge clock_bus_i) disable iff (reset_i)
		$rose(core_done_o) |-> core_req_i);

endmodule

//--- source/riscv_hart_core.sv
`timescale 1ns/1ps

module riscv_hart_core import riscv_hart_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic            clock_bus_i,
	input  logic            reset_i,
	// instruction port
	output logic            inst_req_o,
	output logic [XLEN-1:0] inst_addr_o,
	input  logic [XLEN-1:0] inst_data_i,
	input  logic            inst_done_i,
	// data port
	output logic            data_req_o,
	output logic            data_wren_o,
	output logic [XLEN-1:0] data_addr_o,
	output logic [XLEN-1:0] data_data_o,
	input  logic [XLEN-1:0] data_data_i,
	input  logic            data_done_i,
	// status
	output logic [XLEN-1:0] data_ref_addr_o,
	output exc_e            exception_o
);

	core_state_e     state;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] ir;
	logic [XLEN-1:0] load_q;
	logic            inst_req;
	logic            data_req;
	logic            data_wren;
	logic [XLEN-1:0] data_addr;
	logic [XLEN-1:0] data_wdata;
	exc_e            exc;

	// ------------------------------------------------------------------------
	// instruction fields and immediates
	// ------------------------------------------------------------------------
	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = opcode_e'(ir[6:0]);
	assign funct3 = ir[14:12];
	assign imm_i  = {{20{ir[31]}}, ir[31:20]};
	assign imm_s  = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u  = {ir[31:12], 12'b0};
	assign imm_j  = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	// decode outputs
	alu_op_e         alu_op;
	logic            use_rs2;
	logic            writes_rd;
	logic            illegal;
	logic [XLEN-1:0] imm;

	always_comb begin
		alu_op    = ALU_ADD;
		use_rs2   = 1'b0;
		writes_rd = 1'b0;
		illegal   = 1'b0;
		imm       = imm_i;
		case (opcode)
			OP: begin
				use_rs2   = 1'b1;
				writes_rd = 1'b1;
				case (funct3)
					3'b000:  alu_op = ir[30] ? ALU_SUB : ALU_ADD;
					3'b010:  alu_op = ALU_SLT;
					3'b100:  alu_op = ALU_XOR;
					3'b110:  alu_op = ALU_OR;
					3'b111:  alu_op = ALU_AND;
					default: illegal = 1'b1;
				endcase
			end
			OP_IMM: begin
				writes_rd = 1'b1;
				case (funct3)
					3'b000:  alu_op = ALU_ADD;
					3'b100:  alu_op = ALU_XOR;
					3'b110:  alu_op = ALU_OR;
					3'b111:  alu_op = ALU_AND;
					default: illegal = 1'b1;
				endcase
			end
			LUI: begin
				alu_op    = ALU_PASSB;
				writes_rd = 1'b1;
				imm       = imm_u;
			end
			// word accesses only
			LOAD: begin
				writes_rd = 1'b1;
				illegal   = (funct3 != 3'b010);
			end
			STORE: begin
				imm     = imm_s;
				illegal = (funct3 != 3'b010);
			end
			// beq and bne only
			BRANCH: begin
				alu_op  = ALU_EQ;
				use_rs2 = 1'b1;
				illegal = (funct3[2:1] != 2'b00);
			end
			JAL:     writes_rd = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

	// ------------------------------------------------------------------------
	// register file and alu
	// ------------------------------------------------------------------------
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic [XLEN-1:0] alu_result;
	logic            alu_equal;
	logic            rd_we;
	logic [XLEN-1:0] wb_data;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] next_pc;
	logic            branch_taken;
	logic            is_mem;
	logic            misaligned;

	riscv_regfile regfile_inst (
		.clock_bus_i (clock_bus_i),
		.rs1_addr_i  (ir[19:15]),
		.rs2_addr_i  (ir[24:20]),
		.rs1_data_o  (rs1_data),
		.rs2_data_o  (rs2_data),
		.rd_we_i     (rd_we),
		.rd_addr_i   (ir[11:7]),
		.rd_data_i   (wb_data)
	);

	riscv_alu alu_inst (
		.op_i     (alu_op),
		.a_i      (rs1_data),
		.b_i      (use_rs2 ? rs2_data : imm),
		.result_o (alu_result),
		.equal_o  (alu_equal)
	);

	// regfile is only written in wb, so operands hold from exec to wb
	assign rd_we   = (state == S_WB) && writes_rd;
	assign wb_data = (opcode == LOAD) ? load_q : (opcode == JAL) ? pc_plus4 : alu_result;

	// next pc, funct3[0] flips the compare for bne
	assign pc_plus4     = pc + 32'd4;
	assign branch_taken = (opcode == BRANCH) && (funct3[0] ? !alu_equal : alu_equal);
	assign next_pc      = (opcode == JAL) ? pc + imm_j :
	                      branch_taken ? pc + imm_b : pc_plus4;

	assign is_mem     = (opcode == LOAD) || (opcode == STORE);
	assign misaligned = (alu_result[1:0] != 2'b00);

	// ------------------------------------------------------------------------
	// control fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (reset_i) begin
			state     <= S_FETCH;
			pc        <= RESET_PC;
			inst_req  <= 1'b0;
			data_req  <= 1'b0;
			data_wren <= 1'b0;
			exc       <= EXC_NONE;
		end else begin
			case (state)
				// raise req, wait for the instruction word
				S_FETCH: begin
					if (inst_req && inst_done_i) begin
						inst_req <= 1'b0;
						state    <= S_EXEC;
					end else begin
						inst_req <= 1'b1;
					end
				end
				// faults halt before any data reference goes out
				S_EXEC: begin
					if (illegal) begin
						exc   <= EXC_ILLEGAL;
						state <= S_HALT;
					end else if (is_mem && misaligned) begin
						exc   <= (opcode == LOAD) ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;
						state <= S_HALT;
					end else if (is_mem) begin
						data_req  <= 1'b1;
						data_wren <= (opcode == STORE);
						state     <= S_MEM;
					end else begin
						state <= S_WB;
					end
				end
				S_MEM: begin
					if (data_done_i) begin
						data_req <= 1'b0;
						state    <= S_WB;
					end
				end
				// retire, next fetch request goes out with the new pc
				S_WB: begin
					pc       <= next_pc;
					inst_req <= 1'b1;
					state    <= S_FETCH;
				end
				default: state <= S_HALT;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock_bus_i) begin
		if (state == S_FETCH && inst_req && inst_done_i)
			ir <= inst_data_i;
		if (state == S_EXEC) begin
			data_addr  <= alu_result;
			data_wdata <= rs2_data;
		end
		if (state == S_MEM && data_done_i)
			load_q <= data_data_i;
	end

	assign inst_req_o      = inst_req;
	assign inst_addr_o     = pc;
	assign data_req_o      = data_req;
	assign data_wren_o     = data_wren;
	assign data_addr_o     = data_addr;
	assign data_data_o     = data_wdata;
	assign data_ref_addr_o = pc;
	assign exception_o     = exc;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// data reference held until done
	assert property (@(posedge clock_bus_i) disable iff (reset_i)
		(data_req_o && !data_done_i) |=>
		(data_req_o && $stable(data_addr_o) && $stable(data_data_o) && $stable(data_wren_o)));

	// once an exception is flagged the hart stays quiet
	assert property (@(posedge clock_bus_i) disable iff (reset_i)
		(exception_o != EXC_NONE) |=> (!inst_req_o && !data_req_o && $stable(exception_o)));

endmodule

//--- source/riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile import riscv_hart_pkg::*; (
	input  logic            clock_bus_i,
	// read ports
	input  logic [4:0]      rs1_addr_i,
	input  logic [4:0]      rs2_addr_i,
	output logic [XLEN-1:0] rs1_data_o,
	output logic [XLEN-1:0] rs2_data_o,
	// write port
	input  logic            rd_we_i,
	input  logic [4:0]      rd_addr_i,
	input  logic [XLEN-1:0] rd_data_i
);

	// x1..x31, x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	// write lands on the edge, visible to the next read
	always_ff @(posedge clock_bus_i) begin
		if (rd_we_i && rd_addr_i != 5'd0)
			regs[rd_addr_i] <= rd_data_i;
	end

	// combinational reads, x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

//--- source/riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu import riscv_hart_pkg::*; (
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	output logic [XLEN-1:0] result_o,
	output logic            equal_o
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic            less;

	assign sum  = a_i + b_i;
	assign diff = a_i - b_i;

	// signed compare for slt
	assign less = $signed(a_i) < $signed(b_i);

	// branch condition, core inverts it for bne
	assign equal_o = (a_i == b_i);

	always_comb begin
		case (op_i)
			ALU_ADD:   result_o = sum;
			ALU_SUB:   result_o = diff;
			ALU_AND:   result_o = a_i & b_i;
			ALU_OR:    result_o = a_i | b_i;
			ALU_XOR:   result_o = a_i ^ b_i;
			ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, less};
			// lui, immediate passes straight through
			ALU_PASSB: result_o = b_i;
			ALU_EQ:    result_o = {{(XLEN-1){1'b0}}, equal_o};
			default:   result_o = sum;
		endcase
	end

endmodule

//--- source/riscv_hart_pkg.sv
package riscv_hart_pkg;

	// ------------------------------------------------------------------------
	// machine width and address map
	// ------------------------------------------------------------------------
	localparam int XLEN = 32;

	// data addresses at or above this go to the peripheral controller
	localparam logic [31:0] PER_BASE = 32'h8000_0000;

	// ------------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------------

	// rv32i major opcodes in scope, encoded as instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	// alu operations
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB,
		ALU_EQ
	} alu_op_e;

	// exception codes, the value seen on exception_bus_o
	typedef enum logic [3:0] {
		EXC_NONE,
		EXC_ILLEGAL,
		EXC_LOAD_MISALIGN,
		EXC_STORE_MISALIGN
	} exc_e;

	// multi-cycle core states
	typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT} core_state_e;

endpackage
